//--- logic/vdp_bus_pkg.sv
/*
 * VDP CPU bus definitions
 * I/O port numbers, register numbers and bus widths
 */
package vdp_bus_pkg;

    localparam int DATA_W       = 8;
    localparam int STATUS_SEL_W = 4;
    localparam int VDP_ID_W     = 5;

    // Low two bits of the CPU I/O address
    typedef logic [1:0] cpu_port_t;

    localparam cpu_port_t PORT_VRAM     = 2'd0;
    localparam cpu_port_t PORT_CTRL     = 2'd1;
    localparam cpu_port_t PORT_PALETTE  = 2'd2;
    localparam cpu_port_t PORT_INDIRECT = 2'd3;

    typedef logic [5:0] reg_num_t;

    localparam reg_num_t REG_MODE0        = 6'd0;
    localparam reg_num_t REG_MODE1        = 6'd1;
    localparam reg_num_t REG_FRAME_COL    = 6'd7;
    localparam reg_num_t REG_MODE8        = 6'd8;
    localparam reg_num_t REG_MODE9        = 6'd9;
    localparam reg_num_t REG_BLINK_MODE   = 6'd12;
    localparam reg_num_t REG_BLINK_PERIOD = 6'd13;
    localparam reg_num_t REG_STATUS_SEL   = 6'd15;
    localparam reg_num_t REG_PAL_SEL      = 6'd16;
    localparam reg_num_t REG_INDIRECT     = 6'd17;
    localparam reg_num_t REG_ADJUST       = 6'd18;
    localparam reg_num_t REG_HINT_LINE    = 6'd19;
    localparam reg_num_t REG_VSTART       = 6'd23;

endpackage

//--- logic/vdp_display_pkg.sv
/*
 * VDP display-side definitions
 * Screen modes, palette colour format and dot phases
 */
package vdp_display_pkg;

    localparam int PAL_ENTRIES = 16;

    // GRAPHIC1 first so a cleared mode register decodes to it
    typedef enum logic [3:0] {
        MODE_GRAPHIC1,
        MODE_GRAPHIC2,
        MODE_GRAPHIC3,
        MODE_GRAPHIC4,
        MODE_GRAPHIC5,
        MODE_GRAPHIC6,
        MODE_GRAPHIC7,
        MODE_TEXT1,
        MODE_TEXT1Q,
        MODE_TEXT2,
        MODE_MULTI,
        MODE_MULTIQ,
        MODE_UNDEFINED
    } screen_mode_t;

    typedef struct packed {
        logic [2:0] red;
        logic [2:0] green;
        logic [2:0] blue;
    } rgb333_t;

    typedef logic [3:0] pal_index_t;

    // Display owns the palette in these two phases
    typedef logic [1:0] dot_state_t;
    localparam dot_state_t DOT_PHASE_EVEN_A = 2'd0;
    localparam dot_state_t DOT_PHASE_EVEN_B = 2'd3;

    typedef struct packed {
        logic [2:0] r0;
        logic [1:0] r1;
    } mode_bits_t;

endpackage

//--- logic/palette_wr_if.sv
/*
 * Palette write channel
 * Toggle handshake carrying one colour and its index
 */
interface palette_wr_if;

    logic                        req_toggle;
    logic                        ack_toggle;
    vdp_display_pkg::pal_index_t index;
    vdp_display_pkg::rgb333_t    rgb;

    modport host (
        output req_toggle, index, rgb,
        input  ack_toggle
    );

    modport store (
        input  req_toggle, index, rgb,
        output ack_toggle
    );

endinterface

//--- logic/vdp_cpu_port.sv
/*
 * VDP CPU port logic
 * Port decoding, byte pairing, R16/R17 pointers and read data
 */
module vdp_cpu_port
    import vdp_bus_pkg::*, vdp_display_pkg::*;
(
    input  logic              CLK21M,
    input  logic              RESET,
    input  logic              req,
    input  logic              wrt,
    input  cpu_port_t         adr,
    input  logic [DATA_W-1:0] dbo,
    input  logic [DATA_W-1:0] status_byte,
    output logic              ack,
    output logic [DATA_W-1:0] dbi,
    output logic              reg_wr,
    output reg_num_t          reg_num,
    output logic [DATA_W-1:0] reg_data,
    output logic              status_rd,
    palette_wr_if.host        pal
);

    logic       p1_first;
    logic       p2_first;
    logic [2:0] red_lat;
    logic [2:0] blue_lat;
    pal_index_t r16_pal;
    reg_num_t   r17_num;
    logic       r17_inc;

    assign status_rd = req && !wrt && (adr == PORT_CTRL);

    always_ff @(posedge CLK21M or posedge RESET) begin
        if (RESET) begin
            ack            <= 1'b0;
            reg_wr         <= 1'b0;
            reg_num        <= '0;
            reg_data       <= '0;
            p1_first       <= 1'b1;
            p2_first       <= 1'b1;
            r16_pal        <= '0;
            r17_num        <= '0;
            r17_inc        <= 1'b0;
            pal.req_toggle <= 1'b0;
        end else begin
            ack    <= req;
            reg_wr <= 1'b0;
            if (req && !wrt) begin
                // Status read restarts the control port byte pairing
                if (adr == PORT_CTRL) begin
                    p1_first <= 1'b1;
                end
            end else if (req) begin
                case (adr)
                    PORT_VRAM: begin
                        // VRAM data is not handled in this block
                    end
                    PORT_CTRL: begin
                        if (p1_first) begin
                            p1_first <= 1'b0;
                            reg_data <= dbo;
                        end else begin
                            p1_first <= 1'b1;
                            // Top bits 1x select a register write
                            if (dbo[7]) begin
                                reg_num <= dbo[5:0];
                                reg_wr  <= 1'b1;
                            end
                        end
                    end
                    PORT_PALETTE: begin
                        p2_first <= ~p2_first;
                        if (!p2_first) begin
                            pal.req_toggle <= ~pal.ack_toggle;
                            r16_pal        <= r16_pal + 1'b1;
                        end
                    end
                    PORT_INDIRECT: begin
                        // R17 cannot write itself
                        reg_wr   <= (r17_num != REG_INDIRECT);
                        reg_num  <= r17_num;
                        reg_data <= dbo;
                        if (r17_inc) begin
                            r17_num <= r17_num + 1'b1;
                        end
                    end
                endcase
            end else if (reg_wr) begin
                if (reg_num == REG_PAL_SEL) begin
                    r16_pal  <= reg_data[3:0];
                    p2_first <= 1'b1;
                end
                if (reg_num == REG_INDIRECT) begin
                    r17_num <= reg_data[5:0];
                    r17_inc <= ~reg_data[7];
                end
            end
        end
    end

    // Read data and palette colour assembly
    always_ff @(posedge CLK21M) begin
        if (req && !wrt) begin
            dbi <= (adr == PORT_CTRL) ? status_byte : '1;
        end
        if (req && wrt && (adr == PORT_PALETTE)) begin
            if (p2_first) begin
                red_lat  <= dbo[6:4];
                blue_lat <= dbo[2:0];
            end else begin
                pal.rgb   <= '{red: red_lat, green: dbo[2:0], blue: blue_lat};
                pal.index <= r16_pal;
            end
        end
    end

endmodule

//--- logic/vdp_control_regs.sv
/*
 * VDP control register file
 * Mode bits and display enable are taken over at HSYNC
 */
module vdp_control_regs
    import vdp_bus_pkg::*, vdp_display_pkg::*;
(
    input  logic              CLK21M,
    input  logic              RESET,
    input  logic              hsync,
    input  logic              reg_wr,
    input  reg_num_t          reg_num,
    input  logic [DATA_W-1:0] reg_data,
    output logic              hint_en,
    output logic              sp_size,
    output logic              sp_zoom,
    output logic              blink_hsync,
    output logic              vint_en,
    output logic              disp_on,
    output logic [DATA_W-1:0] frame_col,
    output logic              sp_off,
    output logic              col0_on,
    output logic              pal_mode,
    output logic              interlace,
    output logic              y_dots,
    output logic [DATA_W-1:0] blink_mode,
    output logic [DATA_W-1:0] blink_period,
    output logic [DATA_W-1:0] adjust,
    output logic [DATA_W-1:0] hint_line,
    output logic [DATA_W-1:0] vstart_line,
    output mode_bits_t        mode_bits
);

    // Written values waiting for the next HSYNC
    logic [2:0] r0_mode_wr;
    logic [1:0] r1_mode_wr;
    logic       disp_on_wr;

    always_ff @(posedge CLK21M or posedge RESET) begin
        if (RESET) begin
            r0_mode_wr   <= '0;
            r1_mode_wr   <= '0;
            disp_on_wr   <= 1'b0;
            hint_en      <= 1'b0;
            sp_size      <= 1'b0;
            sp_zoom      <= 1'b0;
            blink_hsync  <= 1'b0;
            vint_en      <= 1'b0;
            frame_col    <= '0;
            sp_off       <= 1'b0;
            col0_on      <= 1'b0;
            pal_mode     <= 1'b0;
            interlace    <= 1'b0;
            y_dots       <= 1'b0;
            blink_mode   <= '0;
            blink_period <= '0;
            adjust       <= '0;
            hint_line    <= '0;
            vstart_line  <= '0;
        end else if (reg_wr) begin
            case (reg_num)
                REG_MODE0: begin
                    r0_mode_wr <= reg_data[3:1];
                    hint_en    <= reg_data[4];
                end
                REG_MODE1: begin
                    sp_zoom     <= reg_data[0];
                    sp_size     <= reg_data[1];
                    blink_hsync <= reg_data[2];
                    r1_mode_wr  <= reg_data[4:3];
                    vint_en     <= reg_data[5];
                    disp_on_wr  <= reg_data[6];
                end
                REG_FRAME_COL: frame_col <= reg_data;
                REG_MODE8: begin
                    sp_off  <= reg_data[1];
                    col0_on <= reg_data[5];
                end
                REG_MODE9: begin
                    pal_mode  <= reg_data[1];
                    interlace <= reg_data[3];
                    y_dots    <= reg_data[7];
                end
                REG_BLINK_MODE:   blink_mode   <= reg_data;
                REG_BLINK_PERIOD: blink_period <= reg_data;
                REG_ADJUST:       adjust       <= reg_data;
                REG_HINT_LINE:    hint_line    <= reg_data;
                REG_VSTART:       vstart_line  <= reg_data;
                default: begin
                end
            endcase
        end
    end

    always_ff @(posedge CLK21M or posedge RESET) begin
        if (RESET) begin
            mode_bits <= '0;
            disp_on   <= 1'b0;
        end else if (hsync) begin
            mode_bits <= '{r0: r0_mode_wr, r1: r1_mode_wr};
            disp_on   <= disp_on_wr;
        end
    end

endmodule

//--- logic/vdp_status_regs.sv
/*
 * VDP status registers
 * R15 selector, status byte assembly and interrupt clears
 */
module vdp_status_regs
    import vdp_bus_pkg::*;
(
    input  logic                CLK21M,
    input  logic                RESET,
    input  logic                reg_wr,
    input  reg_num_t            reg_num,
    input  logic [DATA_W-1:0]   reg_data,
    input  logic                status_rd,
    input  logic                vint_req_n,
    input  logic                hint_req_n,
    input  logic                sp_5th,
    input  logic                sp_collision,
    input  logic [4:0]          sp_5th_num,
    input  logic [VDP_ID_W-1:0] vdp_id,
    input  logic                cmd_tr,
    input  logic                vd,
    input  logic                hd,
    input  logic                cmd_bd,
    input  logic                field,
    input  logic                cmd_ce,
    output logic [DATA_W-1:0]   status_byte,
    output logic                clr_vsync_int,
    output logic                clr_hsync_int
);

    logic [STATUS_SEL_W-1:0] status_sel;

    always_comb begin
        case (status_sel)
            4'd0:    status_byte = {~vint_req_n, sp_5th, sp_collision, sp_5th_num};
            4'd1:    status_byte = {2'b00, vdp_id, ~hint_req_n};
            4'd2:    status_byte = {cmd_tr, vd, hd, cmd_bd, 2'b11, field, cmd_ce};
            default: status_byte = '0;
        endcase
    end

    always_ff @(posedge CLK21M or posedge RESET) begin
        if (RESET) begin
            status_sel    <= '0;
            clr_vsync_int <= 1'b0;
            clr_hsync_int <= 1'b0;
        end else begin
            if (reg_wr && (reg_num == REG_STATUS_SEL)) begin
                status_sel <= reg_data[STATUS_SEL_W-1:0];
            end
            clr_vsync_int <= status_rd && (status_sel == 4'd0);
            // Line interrupt also clears on a new line or a set enable
            clr_hsync_int <= (status_rd && (status_sel == 4'd1)) ||
                             (reg_wr && ((reg_num == REG_HINT_LINE) ||
                                         ((reg_num == REG_MODE0) && reg_data[4])));
        end
    end

endmodule

//--- logic/vdp_mode_decode.sv
/*
 * VDP screen mode decoder
 */
module vdp_mode_decode
    import vdp_display_pkg::*;
(
    input  mode_bits_t   mode_bits,
    output screen_mode_t screen_mode,
    output logic         high_res,
    output logic         sprite_mode2,
    output logic         vram_interleave
);

    // R1 mode bits enter the key swapped
    logic [4:0] mode_key;

    assign mode_key = {mode_bits.r0, mode_bits.r1[0], mode_bits.r1[1]};

    always_comb begin
        case (mode_key)
            5'b00000: screen_mode = MODE_GRAPHIC1;
            5'b00001: screen_mode = MODE_TEXT1;
            5'b00010: screen_mode = MODE_MULTI;
            5'b00100: screen_mode = MODE_GRAPHIC2;
            5'b00101: screen_mode = MODE_TEXT1Q;
            5'b00110: screen_mode = MODE_MULTIQ;
            5'b01000: screen_mode = MODE_GRAPHIC3;
            5'b01001: screen_mode = MODE_TEXT2;
            5'b01100: screen_mode = MODE_GRAPHIC4;
            5'b10000: screen_mode = MODE_GRAPHIC5;
            5'b10100: screen_mode = MODE_GRAPHIC6;
            5'b11100: screen_mode = MODE_GRAPHIC7;
            default:  screen_mode = MODE_UNDEFINED;
        endcase
    end

    assign high_res        = (mode_bits.r0[2:1] == 2'b10) && (mode_bits.r1 == 2'b00);
    assign sprite_mode2    = (mode_bits.r1 == 2'b00) && (mode_bits.r0[2] || mode_bits.r0[1]);
    assign vram_interleave = mode_bits.r0[2] && mode_bits.r0[0];

endmodule

//--- logic/vdp_palette.sv
/*
 * VDP palette memory
 * CPU writes slip in during odd dot phases only
 */
module vdp_palette
    import vdp_display_pkg::*;
(
    input  logic         CLK21M,
    input  logic         RESET,
    input  dot_state_t   dot_state,
    input  pal_index_t   palette_addr,
    output rgb333_t      palette_rgb,
    palette_wr_if.store  pal
);

    rgb333_t    mem [PAL_ENTRIES];
    logic       even_dot;
    logic       wr_own;
    pal_index_t mem_addr;

    assign even_dot = (dot_state == DOT_PHASE_EVEN_A) || (dot_state == DOT_PHASE_EVEN_B);
    assign mem_addr = wr_own ? pal.index : palette_addr;

    always_ff @(posedge CLK21M or posedge RESET) begin
        if (RESET) begin
            wr_own         <= 1'b0;
            pal.ack_toggle <= 1'b0;
        end else begin
            wr_own <= 1'b0;
            if (!even_dot && (pal.req_toggle != pal.ack_toggle)) begin
                // Take the memory for the pending write
                wr_own         <= 1'b1;
                pal.ack_toggle <= ~pal.ack_toggle;
            end
        end
    end

    always_ff @(posedge CLK21M or posedge RESET) begin
        if (RESET) begin
            for (int i = 0; i < PAL_ENTRIES; i++) begin
                mem[i] <= '0;
            end
            palette_rgb <= '0;
        end else begin
            if (wr_own) begin
                mem[mem_addr] <= pal.rgb;
            end
            palette_rgb <= mem[mem_addr];
        end
    end

endmodule

//--- logic/vdp_register_top.sv
/*
 * VDP register block top level
 * CPU ports, control and status registers, mode decode and palette
 */
module vdp_register_top
    import vdp_bus_pkg::*, vdp_display_pkg::*;
(
    input  logic                CLK21M,
    input  logic                RESET,
    input  logic                req,
    input  logic                wrt,
    input  cpu_port_t           adr,
    input  logic [DATA_W-1:0]   dbo,
    input  logic                hsync,
    input  dot_state_t          dot_state,
    input  pal_index_t          palette_addr,
    input  logic                vint_req_n,
    input  logic                hint_req_n,
    input  logic                sp_5th,
    input  logic                sp_collision,
    input  logic [4:0]          sp_5th_num,
    input  logic [VDP_ID_W-1:0] vdp_id,
    input  logic                cmd_tr,
    input  logic                vd,
    input  logic                hd,
    input  logic                cmd_bd,
    input  logic                field,
    input  logic                cmd_ce,
    output logic                ack,
    output logic [DATA_W-1:0]   dbi,
    output rgb333_t             palette_rgb,
    output logic                clr_vsync_int,
    output logic                clr_hsync_int,
    output logic                hint_en,
    output logic                sp_size,
    output logic                sp_zoom,
    output logic                blink_hsync,
    output logic                vint_en,
    output logic                disp_on,
    output logic [DATA_W-1:0]   frame_col,
    output logic                sp_off,
    output logic                col0_on,
    output logic                pal_mode,
    output logic                interlace,
    output logic                y_dots,
    output logic [DATA_W-1:0]   blink_mode,
    output logic [DATA_W-1:0]   blink_period,
    output logic [DATA_W-1:0]   adjust,
    output logic [DATA_W-1:0]   hint_line,
    output logic [DATA_W-1:0]   vstart_line,
    output screen_mode_t        screen_mode,
    output logic                high_res,
    output logic                sprite_mode2,
    output logic                vram_interleave
);

    logic              reg_wr;
    reg_num_t          reg_num;
    logic [DATA_W-1:0] reg_data;
    logic              status_rd;
    logic [DATA_W-1:0] status_byte;
    mode_bits_t        mode_bits;

    palette_wr_if u_pal_if ();

    vdp_cpu_port u_cpu_port (
        .CLK21M      (CLK21M),
        .RESET       (RESET),
        .req         (req),
        .wrt         (wrt),
        .adr         (adr),
        .dbo         (dbo),
        .status_byte (status_byte),
        .ack         (ack),
        .dbi         (dbi),
        .reg_wr      (reg_wr),
        .reg_num     (reg_num),
        .reg_data    (reg_data),
        .status_rd   (status_rd),
        .pal         (u_pal_if.host)
    );

    vdp_control_regs u_control_regs (
        .CLK21M       (CLK21M),
        .RESET        (RESET),
        .hsync        (hsync),
        .reg_wr       (reg_wr),
        .reg_num      (reg_num),
        .reg_data     (reg_data),
        .hint_en      (hint_en),
        .sp_size      (sp_size),
        .sp_zoom      (sp_zoom),
        .blink_hsync  (blink_hsync),
        .vint_en      (vint_en),
        .disp_on      (disp_on),
        .frame_col    (frame_col),
        .sp_off       (sp_off),
        .col0_on      (col0_on),
        .pal_mode     (pal_mode),
        .interlace    (interlace),
        .y_dots       (y_dots),
        .blink_mode   (blink_mode),
        .blink_period (blink_period),
        .adjust       (adjust),
        .hint_line    (hint_line),
        .vstart_line  (vstart_line),
        .mode_bits    (mode_bits)
    );

    vdp_status_regs u_status_regs (
        .CLK21M        (CLK21M),
        .RESET         (RESET),
        .reg_wr        (reg_wr),
        .reg_num       (reg_num),
        .reg_data      (reg_data),
        .status_rd     (status_rd),
        .vint_req_n    (vint_req_n),
        .hint_req_n    (hint_req_n),
        .sp_5th        (sp_5th),
        .sp_collision  (sp_collision),
        .sp_5th_num    (sp_5th_num),
        .vdp_id        (vdp_id),
        .cmd_tr        (cmd_tr),
        .vd            (vd),
        .hd            (hd),
        .cmd_bd        (cmd_bd),
        .field         (field),
        .cmd_ce        (cmd_ce),
        .status_byte   (status_byte),
        .clr_vsync_int (clr_vsync_int),
        .clr_hsync_int (clr_hsync_int)
    );

    vdp_mode_decode u_mode_decode (
        .mode_bits       (mode_bits),
        .screen_mode     (screen_mode),
        .high_res        (high_res),
        .sprite_mode2    (sprite_mode2),
        .vram_interleave (vram_interleave)
    );

    vdp_palette u_palette (
        .CLK21M       (CLK21M),
        .RESET        (RESET),
        .dot_state    (dot_state),
        .palette_addr (palette_addr),
        .palette_rgb  (palette_rgb),
        .pal          (u_pal_if.store)
    );

endmodule

//--- sim/tb_clock_gen.sv
/*
 * Testbench clock and reset source
 */
module tb_clock_gen #(
    parameter int HALF_PERIOD  = 4,
    parameter int RESET_CYCLES = 10
) (
    output logic CLK21M,
    output logic RESET
);

    initial begin
        CLK21M = 1'b0;
        forever #HALF_PERIOD CLK21M = ~CLK21M;
    end

    initial begin
        RESET = 1'b1;
        repeat (RESET_CYCLES) @(posedge CLK21M);
        RESET <= 1'b0;
    end

endmodule

//--- sim/tb_vdp_register.sv
/*
 * Testbench for the VDP register block
 * Runs operations from a pattern file and checks the DUT outputs
 */
module tb_vdp_register
    import vdp_bus_pkg::*, vdp_display_pkg::*;
;

    localparam int ACK_TIMEOUT = 16;
    localparam int PAL_TIMEOUT = 32;
    localparam int RST_TIMEOUT = 64;

    logic CLK21M;
    logic RESET;
    logic req;
    logic wrt;
    cpu_port_t adr;
    logic [DATA_W-1:0] dbo;
    logic hsync;
    dot_state_t dot_state;
    pal_index_t palette_addr;
    logic vint_req_n;
    logic hint_req_n;
    logic sp_5th;
    logic sp_collision;
    logic [4:0] sp_5th_num;
    logic [VDP_ID_W-1:0] vdp_id;
    logic cmd_tr;
    logic vd;
    logic hd;
    logic cmd_bd;
    logic field;
    logic cmd_ce;
    logic ack;
    logic [DATA_W-1:0] dbi;
    rgb333_t palette_rgb;
    logic clr_vsync_int;
    logic clr_hsync_int;
    logic hint_en;
    logic sp_size;
    logic sp_zoom;
    logic blink_hsync;
    logic vint_en;
    logic disp_on;
    logic [DATA_W-1:0] frame_col;
    logic sp_off;
    logic col0_on;
    logic pal_mode;
    logic interlace;
    logic y_dots;
    logic [DATA_W-1:0] blink_mode;
    logic [DATA_W-1:0] blink_period;
    logic [DATA_W-1:0] adjust;
    logic [DATA_W-1:0] hint_line;
    logic [DATA_W-1:0] vstart_line;
    screen_mode_t screen_mode;
    logic high_res;
    logic sprite_mode2;
    logic vram_interleave;

    logic [31:0] rng_state;
    int vsync_clears;
    int hsync_clears;

    tb_clock_gen u_clock_gen (
        .CLK21M (CLK21M),
        .RESET  (RESET)
    );

    vdp_register_top u_dut (.*);

    // Free-running dot phase
    always @(posedge CLK21M) begin
        dot_state <= dot_state + 1'b1;
    end

    // Count clear pulses at the falling edge
    always @(negedge CLK21M) begin
        if (clr_vsync_int) begin
            vsync_clears = vsync_clears + 1;
        end
        if (clr_hsync_int) begin
            hsync_clears = hsync_clears + 1;
        end
    end

    task automatic fail_now(input string what);
        $display("Test failed");
        $fatal(1, "%s", what);
    endtask

    task automatic check_byte(input string name, input logic [DATA_W-1:0] exp,
                              input logic [DATA_W-1:0] act);
        if (act !== exp) begin
            $display("** Error: %s expected %h actual %h", name, exp, act);
            fail_now("byte value mismatch");
        end
    endtask

    task automatic check_rgb(input string name, input rgb333_t exp, input rgb333_t act);
        if (act !== exp) begin
            $display("** Error: %s expected %h actual %h", name, exp, act);
            fail_now("palette colour mismatch");
        end
    endtask

    task automatic check_mode(input string name, input screen_mode_t exp,
                              input screen_mode_t act);
        if (act !== exp) begin
            $display("** Error: %s expected %s actual %s", name, exp.name(), act.name());
            fail_now("screen mode mismatch");
        end
    endtask

    function automatic logic [31:0] next_random(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // S#0, S#1 and S#2 layouts from the status inputs
    function automatic logic [7:0] status_expected(input logic [3:0] sel, input logic [31:0] r);
        case (sel)
            4'd0: return {~r[0], r[2], r[3], r[8:4]};
            4'd1: return {2'b00, r[13:9], ~r[1]};
            4'd2: return {r[14], r[15], r[16], r[17], 2'b11, r[18], r[19]};
            default: return 8'h00;
        endcase
    endfunction

    function automatic logic [7:0] reg_output(input logic [7:0] num);
        case (num)
            8'h07: return frame_col;
            8'h0c: return blink_mode;
            8'h0d: return blink_period;
            8'h12: return adjust;
            8'h13: return hint_line;
            8'h17: return vstart_line;
            default: return 8'hxx;
        endcase
    endfunction

    task automatic wait_ack();
        int cycles;
        cycles = 0;
        @(negedge CLK21M);
        while (!ack) begin
            cycles++;
            if (cycles > ACK_TIMEOUT) begin
                fail_now("no ack from the DUT within the timeout");
            end
            @(negedge CLK21M);
        end
    endtask

    task automatic bus_access(input logic is_wr, input cpu_port_t port,
                              input logic [7:0] data);
        @(posedge CLK21M);
        req <= 1'b1;
        wrt <= is_wr;
        adr <= port;
        dbo <= data;
        @(posedge CLK21M);
        req <= 1'b0;
        wrt <= 1'b0;
        wait_ack();
    endtask

    task automatic status_read(input logic [3:0] sel, input logic [7:0] exp_other,
                               input cpu_port_t port);
        logic [7:0] exp;
        rng_state = next_random(rng_state);
        @(posedge CLK21M);
        vint_req_n   <= rng_state[0];
        hint_req_n   <= rng_state[1];
        sp_5th       <= rng_state[2];
        sp_collision <= rng_state[3];
        sp_5th_num   <= rng_state[8:4];
        vdp_id       <= rng_state[13:9];
        cmd_tr       <= rng_state[14];
        vd           <= rng_state[15];
        hd           <= rng_state[16];
        cmd_bd       <= rng_state[17];
        field        <= rng_state[18];
        cmd_ce       <= rng_state[19];
        exp = (port == PORT_CTRL) ? status_expected(sel, rng_state) : exp_other;
        bus_access(1'b0, port, 8'h00);
        check_byte("port read", exp, dbi);
    endtask

    task automatic pulse_hsync();
        @(posedge CLK21M);
        hsync <= 1'b1;
        @(posedge CLK21M);
        hsync <= 1'b0;
    endtask

    task automatic check_palette(input pal_index_t idx, input rgb333_t exp);
        int cycles;
        @(posedge CLK21M);
        palette_addr <= idx;
        cycles = 0;
        @(negedge CLK21M);
        while ((palette_rgb !== exp) && (cycles < PAL_TIMEOUT)) begin
            cycles++;
            @(negedge CLK21M);
        end
        check_rgb("palette entry", exp, palette_rgb);
    endtask

    initial begin
        int fd;
        int cycles;
        int n;
        int vsync_base;
        int hsync_base;
        string line;
        byte op;
        logic [15:0] tgt;
        logic [15:0] val;
        logic [15:0] exp;

        req          = 1'b0;
        wrt          = 1'b0;
        adr          = PORT_VRAM;
        dbo          = '0;
        hsync        = 1'b0;
        dot_state    = '0;
        palette_addr = '0;
        vint_req_n   = 1'b1;
        hint_req_n   = 1'b1;
        sp_5th       = 1'b0;
        sp_collision = 1'b0;
        sp_5th_num   = '0;
        vdp_id       = '0;
        cmd_tr       = 1'b0;
        vd           = 1'b0;
        hd           = 1'b0;
        cmd_bd       = 1'b0;
        field        = 1'b0;
        cmd_ce       = 1'b0;
        rng_state    = 32'h024656b2;
        vsync_clears = 0;
        hsync_clears = 0;
        vsync_base   = 0;
        hsync_base   = 0;

        cycles = 0;
        @(negedge CLK21M);
        while (RESET) begin
            cycles++;
            if (cycles > RST_TIMEOUT) begin
                fail_now("reset was never released");
            end
            @(negedge CLK21M);
        end
        check_byte("ack after reset", 8'h00, {7'b0, ack});
        check_byte("clear pulses after reset", 8'h00, {6'b0, clr_vsync_int, clr_hsync_int});
        check_byte("control flags after reset", 8'h00,
                   {hint_en, sp_size, sp_zoom, blink_hsync, vint_en, disp_on, sp_off, col0_on});
        check_byte("R9 flags after reset", 8'h00, {5'b0, pal_mode, interlace, y_dots});
        check_byte("blink mode after reset", 8'h00, blink_mode);
        check_byte("blink period after reset", 8'h00, blink_period);
        check_byte("vstart line after reset", 8'h00, vstart_line);

        fd = $fopen("sim/vdp_reg_patterns.txt", "r");
        if (fd == 0) begin
            fail_now("cannot open the pattern file");
        end
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            if ((line.len() == 0) || (line[0] == "#")) begin
                continue;
            end
            n = $sscanf(line, "%c %h %h %h", op, tgt, val, exp);
            if (n < 4) begin
                continue;
            end
            case (op)
                "w": bus_access(1'b1, tgt[1:0], val[7:0]);
                "r": status_read(val[3:0], exp[7:0], tgt[1:0]);
                "h": pulse_hsync();
                "c": begin
                    @(negedge CLK21M);
                    check_byte("register output", exp[7:0], reg_output(tgt[7:0]));
                end
                "m": begin
                    @(negedge CLK21M);
                    check_mode("screen mode", screen_mode_t'(val[3:0]), screen_mode);
                    check_byte("mode flags", exp[7:0],
                               {4'b0, disp_on, high_res, sprite_mode2, vram_interleave});
                end
                "p": check_palette(tgt[3:0], rgb333_t'(exp[8:0]));
                "k": begin
                    @(negedge CLK21M);
                    check_byte("vsync clears", val[7:0], 8'(vsync_clears - vsync_base));
                    check_byte("hsync clears", exp[7:0], 8'(hsync_clears - hsync_base));
                    vsync_base = vsync_clears;
                    hsync_base = hsync_clears;
                end
                default: fail_now("unknown operation in the pattern file");
            endcase
        end
        $fclose(fd);

        $display("Test completed successfully");
        $finish;
    end

endmodule

//--- sim/vdp_reg_patterns.txt
# op target value expected, all hex
# w write port, r read port (value is R15), h hsync, c register, m mode, p palette, k clears
c 07 00 00
c 13 00 00
c 12 00 00
m 00 00 00
k 00 00 00
w 01 44 00
r 01 00 00
w 01 3c 00
w 01 87 00
c 07 00 3c
k 00 01 00
w 01 5a 00
w 01 93 00
c 13 00 5a
k 00 00 01
w 01 a5 00
w 01 92 00
c 12 00 a5
w 01 0c 00
w 01 91 00
w 03 aa 00
w 03 55 00
c 0c 00 aa
c 0d 00 55
w 01 92 00
w 01 91 00
w 03 11 00
w 03 22 00
c 12 00 22
w 01 91 00
w 01 91 00
w 03 33 00
c 12 00 22
w 01 06 00
w 01 80 00
w 01 40 00
w 01 81 00
m 00 00 00
h 00 00 00
m 00 03 0a
w 01 04 00
w 01 80 00
w 01 50 00
w 01 81 00
h 00 00 00
m 00 09 08
w 01 0e 00
w 01 80 00
w 01 40 00
w 01 81 00
m 00 09 08
h 00 00 00
m 00 06 0b
k 00 00 00
w 01 02 00
w 01 90 00
w 02 53 00
w 02 06 00
w 02 21 00
w 02 07 00
p 02 00 173
p 03 00 0b9
r 01 00 00
w 01 01 00
w 01 8f 00
r 01 01 00
w 01 02 00
w 01 8f 00
r 01 02 00
w 01 05 00
w 01 8f 00
r 01 05 00
r 02 00 ff
k 00 01 01

//--- src.f
logic/vdp_bus_pkg.sv
logic/vdp_display_pkg.sv
logic/palette_wr_if.sv
logic/vdp_cpu_port.sv
logic/vdp_control_regs.sv
logic/vdp_status_regs.sv
logic/vdp_mode_decode.sv
logic/vdp_palette.sv
logic/vdp_register_top.sv
sim/tb_clock_gen.sv
sim/tb_vdp_register.sv

//--- Makefile
VERILATOR ?= verilator
FILELIST  ?= src.f
TB_TOP    ?= tb_vdp_register
RTL_TOP   ?= vdp_register_top
BUILD_DIR ?= obj_dir
VFLAGS    ?=

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing $(VFLAGS) --top-module $(TB_TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary --timing $(VFLAGS) --top-module $(TB_TOP) \
		-Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TB_TOP)

clean:
	rm -rf $(BUILD_DIR)
